//--- logic/exu_mem_pkg.sv
package exu_mem_pkg;

    // Data and address width of the memory path
    parameter int XLEN = 64;

    // Power-of-two store queue depth used by the top level
    parameter int SQ_DEPTH_DEFAULT = 4;

    // Byte address
    typedef logic [XLEN-1:0] addr_t;

    typedef logic [XLEN-1:0] data_t;

    // Bus write mask with eight bits per enabled byte
    typedef logic [XLEN-1:0] mask_t;

    typedef logic [5:0] robid_t;
    typedef logic [5:0] preg_t;

    // Access size of a load or store
    typedef enum logic [1:0] {
        LS_BYTE   = 2'b00,
        LS_HALF   = 2'b01,
        LS_WORD   = 2'b10,
        LS_DOUBLE = 2'b11
    } ls_size_e;

    // Trinity bus operation
    typedef enum logic [1:0] {
        TBUS_READ  = 2'b00,
        TBUS_WRITE = 2'b01
    } tbus_optype_e;

endpackage

//--- logic/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   mem_instr_valid,
    output logic                   mem_instr_ready,
    input  exu_mem_pkg::robid_t    mem_robid,
    input  exu_mem_pkg::preg_t     mem_prd,
    input  exu_mem_pkg::data_t     mem_src1,
    input  exu_mem_pkg::data_t     mem_src2,
    input  exu_mem_pkg::data_t     mem_imm,
    input  logic                   mem_is_load,
    input  logic                   mem_is_store,
    input  logic                   mem_is_unsigned,
    input  exu_mem_pkg::ls_size_e  mem_ls_size,
    input  logic                   sq_full,
    input  logic                   sq_empty,
    input  logic                   load_ready,
    output logic                   sq_push,
    output exu_mem_pkg::addr_t     sq_addr,
    output exu_mem_pkg::data_t     sq_data,
    output exu_mem_pkg::mask_t     sq_mask,
    output logic                   load_valid,
    output exu_mem_pkg::addr_t     load_addr,
    output logic [2:0]             load_offset,
    output exu_mem_pkg::ls_size_e  load_size,
    output logic                   load_unsigned,
    output exu_mem_pkg::robid_t    load_robid,
    output exu_mem_pkg::preg_t     load_prd
);
    import exu_mem_pkg::*;

    logic       hold_valid;
    logic       hold_load;
    logic       hold_unsigned;
    ls_size_e   hold_size;
    robid_t     hold_robid;
    preg_t      hold_prd;
    addr_t      hold_addr;
    data_t      hold_src2;
    logic [5:0] lane_shift;
    mask_t      size_mask;
    logic       load_go;

    assign mem_instr_ready = ~hold_valid;

    // Loads wait for the queue to drain since there is no forwarding
    assign load_valid = hold_valid & hold_load & sq_empty;
    assign load_go    = load_valid & load_ready;
    assign load_addr  = hold_addr;

    assign sq_push = hold_valid & ~hold_load & ~sq_full;
    assign sq_addr = hold_addr;

    // Byte lane placement within the 64-bit bus word
    assign lane_shift = {hold_addr[2:0], 3'b000};

    always_comb begin
        case (hold_size)
            LS_BYTE: size_mask = 64'h0000_0000_0000_00ff;
            LS_HALF: size_mask = 64'h0000_0000_0000_ffff;
            LS_WORD: size_mask = 64'h0000_0000_ffff_ffff;
            default: size_mask = '1;
        endcase
    end

    assign sq_data = hold_src2 << lane_shift;
    assign sq_mask = size_mask << lane_shift;

    always_ff @(posedge clock) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else if (mem_instr_valid && mem_instr_ready) begin
            hold_valid <= mem_is_load | mem_is_store;
        end else if (sq_push || load_go) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (mem_instr_valid && mem_instr_ready) begin
            hold_load     <= mem_is_load;
            hold_unsigned <= mem_is_unsigned;
            hold_size     <= mem_ls_size;
            hold_robid    <= mem_robid;
            hold_prd      <= mem_prd;
            hold_addr     <= mem_src1 + mem_imm;
            hold_src2     <= mem_src2;
        end
    end

    // Format fields stay put while the load is in flight
    always_ff @(posedge clock) begin
        if (load_go) begin
            load_offset   <= hold_addr[2:0];
            load_size     <= hold_size;
            load_unsigned <= hold_unsigned;
            load_robid    <= hold_robid;
            load_prd      <= hold_prd;
        end
    end

endmodule

//--- logic/store_queue.sv
`timescale 1ns/1ns

module store_queue #(
    parameter int SQ_DEPTH = exu_mem_pkg::SQ_DEPTH_DEFAULT
) (
    input  logic               clock,
    input  logic               rst,
    input  logic               sq_push,
    input  exu_mem_pkg::addr_t sq_addr,
    input  exu_mem_pkg::data_t sq_data,
    input  exu_mem_pkg::mask_t sq_mask,
    input  logic               sq_pop,
    output logic               sq_head_valid,
    output exu_mem_pkg::addr_t sq_head_addr,
    output exu_mem_pkg::data_t sq_head_data,
    output exu_mem_pkg::mask_t sq_head_mask,
    output logic               sq_full,
    output logic               sq_empty
);
    import exu_mem_pkg::*;

    localparam int PTR_W = $clog2(SQ_DEPTH);

    addr_t addr_mem [SQ_DEPTH];
    data_t data_mem [SQ_DEPTH];
    mask_t mask_mem [SQ_DEPTH];

    // Top bit of each pointer is the wrap flag
    logic [PTR_W:0] head_ptr;
    logic [PTR_W:0] tail_ptr;

    assign sq_empty = (head_ptr == tail_ptr);
    assign sq_full  = (head_ptr[PTR_W] != tail_ptr[PTR_W]) &&
                      (head_ptr[PTR_W-1:0] == tail_ptr[PTR_W-1:0]);

    assign sq_head_valid = ~sq_empty;
    assign sq_head_addr  = addr_mem[head_ptr[PTR_W-1:0]];
    assign sq_head_data  = data_mem[head_ptr[PTR_W-1:0]];
    assign sq_head_mask  = mask_mem[head_ptr[PTR_W-1:0]];

    always_ff @(posedge clock) begin
        if (rst) begin
            tail_ptr <= '0;
        end else if (sq_push && !sq_full) begin
            tail_ptr <= tail_ptr + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            head_ptr <= '0;
        end else if (sq_pop && !sq_empty) begin
            head_ptr <= head_ptr + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (sq_push && !sq_full) begin
            addr_mem[tail_ptr[PTR_W-1:0]] <= sq_addr;
            data_mem[tail_ptr[PTR_W-1:0]] <= sq_data;
            mask_mem[tail_ptr[PTR_W-1:0]] <= sq_mask;
        end
    end

endmodule

//--- logic/dcache_arb.sv
`timescale 1ns/1ns

module dcache_arb (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      load_valid,
    input  exu_mem_pkg::addr_t        load_addr,
    output logic                      load_ready,
    input  logic                      sq_head_valid,
    input  exu_mem_pkg::addr_t        sq_head_addr,
    input  exu_mem_pkg::data_t        sq_head_data,
    input  exu_mem_pkg::mask_t        sq_head_mask,
    output logic                      sq_pop,
    output logic                      tbus_index_valid,
    input  logic                      tbus_index_ready,
    output exu_mem_pkg::addr_t        tbus_index,
    output exu_mem_pkg::data_t        tbus_write_data,
    output exu_mem_pkg::mask_t        tbus_write_mask,
    output exu_mem_pkg::tbus_optype_e tbus_operation_type,
    input  logic                      tbus_operation_done,
    output logic                      load_done
);
    import exu_mem_pkg::*;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_REQ,
        ARB_WAIT
    } arb_state_e;

    arb_state_e   state;
    logic         req_is_load;
    addr_t        req_addr;
    data_t        req_data;
    mask_t        req_mask;
    tbus_optype_e req_type;

    // Only one operation on the bus at a time
    assign load_ready = (state == ARB_IDLE);

    assign tbus_index_valid    = (state == ARB_REQ);
    assign tbus_index          = {req_addr[XLEN-1:3], 3'b000};
    assign tbus_write_data     = req_data;
    assign tbus_write_mask     = req_mask;
    assign tbus_operation_type = req_type;

    // Queue entry leaves as soon as the bus takes it
    assign sq_pop    = (state == ARB_REQ) & tbus_index_ready & ~req_is_load;
    assign load_done = (state == ARB_WAIT) & tbus_operation_done & req_is_load;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= ARB_IDLE;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (load_valid || sq_head_valid) begin
                        state <= ARB_REQ;
                    end
                end
                ARB_REQ: begin
                    if (tbus_index_ready) begin
                        state <= ARB_WAIT;
                    end
                end
                ARB_WAIT: begin
                    if (tbus_operation_done) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Load wins over the store head
    always_ff @(posedge clock) begin
        if (state == ARB_IDLE) begin
            if (load_valid) begin
                req_is_load <= 1'b1;
                req_addr    <= load_addr;
                req_data    <= '0;
                req_mask    <= '0;
                req_type    <= TBUS_READ;
            end else if (sq_head_valid) begin
                req_is_load <= 1'b0;
                req_addr    <= sq_head_addr;
                req_data    <= sq_head_data;
                req_mask    <= sq_head_mask;
                req_type    <= TBUS_WRITE;
            end
        end
    end

endmodule

//--- logic/mem_writeback.sv
`timescale 1ns/1ns

module mem_writeback (
    input  logic                  clock,
    input  logic                  rst,
    input  logic [2:0]            load_offset,
    input  exu_mem_pkg::ls_size_e load_size,
    input  logic                  load_unsigned,
    input  exu_mem_pkg::robid_t   load_robid,
    input  exu_mem_pkg::preg_t    load_prd,
    input  logic                  load_done,
    input  exu_mem_pkg::data_t    tbus_read_data,
    output logic                  memwb_instr_valid,
    output exu_mem_pkg::robid_t   memwb_robid,
    output exu_mem_pkg::preg_t    memwb_prd,
    output exu_mem_pkg::data_t    memwb_result
);
    import exu_mem_pkg::*;

    data_t shifted;
    data_t result;

    assign shifted = tbus_read_data >> {load_offset, 3'b000};

    // Cut to size, then sign or zero extend
    always_comb begin
        case (load_size)
            LS_BYTE: result = {{56{~load_unsigned & shifted[7]}}, shifted[7:0]};
            LS_HALF: result = {{48{~load_unsigned & shifted[15]}}, shifted[15:0]};
            LS_WORD: result = {{32{~load_unsigned & shifted[31]}}, shifted[31:0]};
            default: result = shifted;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            memwb_instr_valid <= 1'b0;
        end else begin
            memwb_instr_valid <= load_done;
        end
    end

    always_ff @(posedge clock) begin
        if (load_done) begin
            memwb_robid  <= load_robid;
            memwb_prd    <= load_prd;
            memwb_result <= result;
        end
    end

endmodule

//--- logic/exu_mem_top.sv
`timescale 1ns/1ns

module exu_mem_top #(
    parameter int SQ_DEPTH = exu_mem_pkg::SQ_DEPTH_DEFAULT
) (
    input  logic                      clock,
    input  logic                      rst,

    // Issue port
    input  logic                      mem_instr_valid,
    output logic                      mem_instr_ready,
    input  exu_mem_pkg::robid_t       mem_robid,
    input  exu_mem_pkg::preg_t        mem_prd,
    input  exu_mem_pkg::data_t        mem_src1,
    input  exu_mem_pkg::data_t        mem_src2,
    input  exu_mem_pkg::data_t        mem_imm,
    input  logic                      mem_is_load,
    input  logic                      mem_is_store,
    input  logic                      mem_is_unsigned,
    input  exu_mem_pkg::ls_size_e     mem_ls_size,

    // Trinity bus
    output logic                      tbus_index_valid,
    input  logic                      tbus_index_ready,
    output exu_mem_pkg::addr_t        tbus_index,
    output exu_mem_pkg::data_t        tbus_write_data,
    output exu_mem_pkg::mask_t        tbus_write_mask,
    output exu_mem_pkg::tbus_optype_e tbus_operation_type,
    input  exu_mem_pkg::data_t        tbus_read_data,
    input  logic                      tbus_operation_done,

    // Load writeback
    output logic                      memwb_instr_valid,
    output exu_mem_pkg::robid_t       memwb_robid,
    output exu_mem_pkg::preg_t        memwb_prd,
    output exu_mem_pkg::data_t        memwb_result
);
    import exu_mem_pkg::*;

    // Unit to store queue
    logic       sq_push;
    addr_t      sq_addr;
    data_t      sq_data;
    mask_t      sq_mask;
    logic       sq_full;
    logic       sq_empty;

    // Store queue to arbiter
    logic       sq_head_valid;
    addr_t      sq_head_addr;
    data_t      sq_head_data;
    mask_t      sq_head_mask;
    logic       sq_pop;

    // Load path
    logic       load_valid;
    logic       load_ready;
    addr_t      load_addr;
    logic [2:0] load_offset;
    ls_size_e   load_size;
    logic       load_unsigned;
    robid_t     load_robid;
    preg_t      load_prd;
    logic       load_done;

    load_store_unit u_load_store_unit (.*);

    store_queue #(
        .SQ_DEPTH(SQ_DEPTH)
    ) u_store_queue (.*);

    dcache_arb u_dcache_arb (.*);

    mem_writeback u_mem_writeback (.*);

endmodule

//--- testbench/tbus_memory_model.sv
`timescale 1ns/1ns

module tbus_memory_model (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      tbus_index_valid,
    output logic                      tbus_index_ready,
    input  exu_mem_pkg::addr_t        tbus_index,
    input  exu_mem_pkg::data_t        tbus_write_data,
    input  exu_mem_pkg::mask_t        tbus_write_mask,
    input  exu_mem_pkg::tbus_optype_e tbus_operation_type,
    output exu_mem_pkg::data_t        tbus_read_data,
    output logic                      tbus_operation_done
);
    import exu_mem_pkg::*;

    // Word storage keyed by bus index
    data_t words [addr_t];
    logic  ready_q;
    logic  busy;
    int    done_wait;
    data_t pending_read;

    // Stall holds the bus off for back-pressure tests
    assign tbus_index_ready = ready_q & ~stall;

    // Unwritten words read back as a hash of the full index
    function automatic data_t fill_word(input addr_t index);
        return index ^ {index[31:0], index[63:32]} ^ 64'h9e37_79b9_7f4a_7c15;
    endfunction

    always @(posedge clock) begin : bus_model
        data_t old;
        if (rst) begin
            ready_q             <= 1'b0;
            busy                <= 1'b0;
            done_wait           <= 0;
            tbus_operation_done <= 1'b0;
            tbus_read_data      <= '0;
        end else begin
            tbus_operation_done <= 1'b0;
            if (tbus_index_valid && tbus_index_ready) begin
                old = words.exists(tbus_index) ? words[tbus_index] : fill_word(tbus_index);
                if (tbus_operation_type == TBUS_WRITE) begin
                    words[tbus_index] = (old & ~tbus_write_mask) |
                                        (tbus_write_data & tbus_write_mask);
                end
                pending_read <= old;
                busy         <= 1'b1;
                ready_q      <= 1'b0;
                done_wait    <= $urandom_range(3, 0);
            end else if (busy) begin
                if (done_wait == 0) begin
                    tbus_operation_done <= 1'b1;
                    tbus_read_data      <= pending_read;
                    busy                <= 1'b0;
                end else begin
                    done_wait <= done_wait - 1;
                end
            end else begin
                ready_q <= ($urandom_range(3, 0) != 0);
            end
        end
    end

endmodule

//--- testbench/tb_exu_mem.sv
`timescale 1ns/1ns

module tb_exu_mem;
    import exu_mem_pkg::*;

    localparam int    CLK_PERIOD = 4;
    localparam int    NUM_TESTS  = 5;
    localparam int    SQ_DEPTH   = SQ_DEPTH_DEFAULT;
    localparam addr_t REGION     = 64'h0000_0000_8000_1000;

    logic         clock;
    logic         rst;
    logic         stall;
    logic         mem_instr_valid;
    logic         mem_instr_ready;
    robid_t       mem_robid;
    preg_t        mem_prd;
    data_t        mem_src1;
    data_t        mem_src2;
    data_t        mem_imm;
    logic         mem_is_load;
    logic         mem_is_store;
    logic         mem_is_unsigned;
    ls_size_e     mem_ls_size;
    logic         tbus_index_valid;
    logic         tbus_index_ready;
    addr_t        tbus_index;
    data_t        tbus_write_data;
    mask_t        tbus_write_mask;
    tbus_optype_e tbus_operation_type;
    data_t        tbus_read_data;
    logic         tbus_operation_done;
    logic         memwb_instr_valid;
    robid_t       memwb_robid;
    preg_t        memwb_prd;
    data_t        memwb_result;

    // Reference bytes, plus expected bus writes and writebacks in order
    logic [7:0] ref_mem [addr_t];
    addr_t      exp_index_q [$];
    data_t      exp_data_q [$];
    mask_t      exp_mask_q [$];
    robid_t     exp_robid_q [$];
    preg_t      exp_prd_q [$];
    data_t      exp_result_q [$];

    int           err_cnt;
    int           test_err_base;
    int           writes_seen;
    int           base_writes;
    logic         held_valid;
    addr_t        held_index;
    data_t        held_data;
    mask_t        held_mask;
    tbus_optype_e held_type;

    exu_mem_top #(.SQ_DEPTH(SQ_DEPTH)) UUT (.*);

    tbus_memory_model u_memory (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("Timeout: the tests did not finish in time");
        $display("Done: errors found");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        err_cnt++;
        $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        err_cnt++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got == exp) else report_mismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic end_test(input int num, input string name);
        $display("Test %0d %s: %s, %0d errors", num, name,
                 (err_cnt == test_err_base) ? "passed" : "failed", err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // Random naturally aligned address inside the test region
    function automatic addr_t pick_address(input ls_size_e size);
        int off;
        off = int'($urandom_range(7, 0)) & ~((1 << size) - 1);
        return REGION + addr_t'(8 * $urandom_range(7, 0)) + addr_t'(off);
    endfunction

    // Issue one instruction and record what the bus and writeback must show
    task automatic issue_op(input logic is_load, input logic uns, input ls_size_e size,
                            input addr_t addr, input data_t src2);
        data_t  src1;
        robid_t robid;
        preg_t  prd;
        int     nbytes;
        int     off;
        int     b;
        data_t  value;
        mask_t  mask;
        src1   = {$urandom, $urandom};
        robid  = robid_t'($urandom);
        prd    = preg_t'($urandom);
        nbytes = 1 << size;
        off    = int'(addr[2:0]);
        @(posedge clock);
        mem_instr_valid <= 1'b1;
        mem_src1        <= src1;
        mem_imm         <= addr - src1;
        mem_src2        <= src2;
        mem_is_load     <= is_load;
        mem_is_store    <= !is_load;
        mem_is_unsigned <= uns;
        mem_ls_size     <= size;
        mem_robid       <= robid;
        mem_prd         <= prd;
        @(posedge clock);
        while (!mem_instr_ready) @(posedge clock);
        mem_instr_valid <= 1'b0;
        value = '0;
        mask  = '0;
        if (is_load) begin
            for (b = 0; b < nbytes; b++) value[8*b +: 8] = ref_mem[addr + addr_t'(b)];
            if (!uns && nbytes < 8 && value[8*nbytes-1]) begin
                for (b = nbytes; b < 8; b++) value[8*b +: 8] = 8'hff;
            end
            exp_robid_q.push_back(robid);
            exp_prd_q.push_back(prd);
            exp_result_q.push_back(value);
        end else begin
            for (b = 0; b < nbytes; b++) begin
                mask[8*(off+b) +: 8]      = 8'hff;
                ref_mem[addr + addr_t'(b)] = src2[8*b +: 8];
            end
            exp_index_q.push_back({addr[63:3], 3'b000});
            exp_data_q.push_back(src2 << (8 * off));
            exp_mask_q.push_back(mask);
        end
    endtask

    task automatic wait_drain();
        while (exp_index_q.size() != 0 || exp_result_q.size() != 0 || !mem_instr_ready)
            @(posedge clock);
        repeat (4) @(posedge clock);
    endtask

    always @(posedge clock) begin : bus_monitor
        if (!rst && tbus_index_valid && tbus_index_ready && tbus_operation_type == TBUS_WRITE) begin
            writes_seen++;
            if (exp_index_q.size() == 0) begin
                report_failure("store on the bus with none expected");
            end else begin
                assert (tbus_index == exp_index_q[0])
                    else report_mismatch("tbus_index", tbus_index, exp_index_q[0]);
                assert (tbus_write_data == exp_data_q[0])
                    else report_mismatch("tbus_write_data", tbus_write_data, exp_data_q[0]);
                assert (tbus_write_mask == exp_mask_q[0])
                    else report_mismatch("tbus_write_mask", tbus_write_mask, exp_mask_q[0]);
                void'(exp_index_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_mask_q.pop_front());
            end
        end
    end

    always @(posedge clock) begin : writeback_monitor
        if (!rst && memwb_instr_valid) begin
            if (exp_result_q.size() == 0) begin
                report_failure("writeback strobe with no load pending");
            end else begin
                assert (memwb_robid == exp_robid_q[0])
                    else report_mismatch("memwb_robid", 64'(memwb_robid), 64'(exp_robid_q[0]));
                assert (memwb_prd == exp_prd_q[0])
                    else report_mismatch("memwb_prd", 64'(memwb_prd), 64'(exp_prd_q[0]));
                assert (memwb_result == exp_result_q[0])
                    else report_mismatch("memwb_result", memwb_result, exp_result_q[0]);
                void'(exp_robid_q.pop_front());
                void'(exp_prd_q.pop_front());
                void'(exp_result_q.pop_front());
            end
        end
    end

    // Request seen but not taken in the previous cycle
    always @(posedge clock) begin
        held_valid <= !rst && tbus_index_valid && !tbus_index_ready;
        held_index <= tbus_index;
        held_data  <= tbus_write_data;
        held_mask  <= tbus_write_mask;
        held_type  <= tbus_operation_type;
    end

    assert property (@(posedge clock) disable iff (rst) held_valid |-> tbus_index_valid)
        else report_failure("tbus_index_valid dropped before the request was taken");
    assert property (@(posedge clock) disable iff (rst) held_valid |-> tbus_index == held_index)
        else report_mismatch("tbus_index", $sampled(tbus_index), $sampled(held_index));
    assert property (@(posedge clock) disable iff (rst)
                     held_valid |-> tbus_write_data == held_data)
        else report_mismatch("tbus_write_data", $sampled(tbus_write_data), $sampled(held_data));
    assert property (@(posedge clock) disable iff (rst)
                     held_valid |-> tbus_write_mask == held_mask)
        else report_mismatch("tbus_write_mask", $sampled(tbus_write_mask), $sampled(held_mask));
    assert property (@(posedge clock) disable iff (rst)
                     held_valid |-> tbus_operation_type == held_type)
        else report_mismatch("tbus_operation_type", 64'($sampled(tbus_operation_type)),
                             64'($sampled(held_type)));

    initial begin : main
        int i;
        int s;
        int u;
        addr_t addr;
        void'($urandom(32'h18fd));
        rst             = 1'b1;
        stall           = 1'b0;
        mem_instr_valid = 1'b0;
        mem_robid       = '0;
        mem_prd         = '0;
        mem_src1        = '0;
        mem_src2        = '0;
        mem_imm         = '0;
        mem_is_load     = 1'b0;
        mem_is_store    = 1'b0;
        mem_is_unsigned = 1'b0;
        mem_ls_size     = LS_BYTE;
        err_cnt         = 0;
        test_err_base   = 0;
        writes_seen     = 0;
        repeat (8) @(posedge clock);
        rst <= 1'b0;
        @(posedge clock);
        check_bit("mem_instr_ready", mem_instr_ready, 1'b1);
        check_bit("tbus_index_valid", tbus_index_valid, 1'b0);
        check_bit("memwb_instr_valid", memwb_instr_valid, 1'b0);
        end_test(1, "reset state");

        // Fill the whole region, then some narrow stores
        for (i = 0; i < 8; i++) issue_op(1'b0, 1'b0, LS_DOUBLE, REGION + addr_t'(8 * i),
                                         {$urandom, $urandom});
        issue_op(1'b0, 1'b0, LS_BYTE, REGION + 64'd3, {$urandom, $urandom});
        issue_op(1'b0, 1'b0, LS_HALF, REGION + 64'd10, {$urandom, $urandom});
        issue_op(1'b0, 1'b0, LS_WORD, REGION + 64'd20, {$urandom, $urandom});
        wait_drain();
        end_test(2, "store order and lanes");

        for (s = 0; s < 4; s++) begin
            for (u = 0; u < 2; u++) begin
                addr = pick_address(ls_size_e'(s));
                issue_op(1'b0, 1'b0, ls_size_e'(s), addr,
                         {$urandom, $urandom} | 64'h8080_8080_8080_8080);
                issue_op(1'b1, u != 0, ls_size_e'(s), addr, '0);
            end
        end
        wait_drain();
        end_test(3, "load sizes and extension");

        stall <= 1'b1;
        base_writes = writes_seen;
        for (i = 0; i <= SQ_DEPTH; i++) issue_op(1'b0, 1'b0, LS_DOUBLE,
                                                 REGION + addr_t'(8 * i), {$urandom, $urandom});
        repeat (10) @(posedge clock);
        check_bit("mem_instr_ready", mem_instr_ready, 1'b0);
        stall <= 1'b0;
        wait_drain();
        if (writes_seen - base_writes != SQ_DEPTH + 1)
            report_mismatch("store count", 64'(writes_seen - base_writes), 64'(SQ_DEPTH + 1));
        end_test(4, "back-pressure");

        for (i = 0; i < 60; i++) begin
            s    = int'($urandom_range(3, 0));
            addr = pick_address(ls_size_e'(s));
            issue_op($urandom_range(1, 0) != 0, $urandom_range(1, 0) != 0, ls_size_e'(s), addr,
                     {$urandom, $urandom});
        end
        wait_drain();
        end_test(5, "random mix");

        $display("Summary: %0d tests run, %0d errors", NUM_TESTS, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- compile.f
logic/exu_mem_pkg.sv
logic/load_store_unit.sv
logic/store_queue.sv
logic/dcache_arb.sv
logic/mem_writeback.sv
logic/exu_mem_top.sv
testbench/tbus_memory_model.sv
testbench/tb_exu_mem.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_exu_mem -o sim_exu_mem
output=$(./obj_dir/sim_exu_mem)
echo "$output"

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
else
    exit 1
fi
